// ==== rtl/retire_pkg.sv ====
// Shared widths, operation encodings and the operation union for the retire back end
// Imported by every block that decodes an op or carries a data word
package retire_pkg;

    localparam int XLEN   = 32;                 // Data word width
    localparam int REG_AW = 5;                  // Register index width
    localparam int STRB_W = XLEN / 8;           // One store strobe per byte

    // Execution unit, upper 3 bits of every op code
    typedef enum logic [2:0] {
        alu    = 3'd0,
        branch = 3'd1,
        memory = 3'd2,
        csr    = 3'd3,
        other  = 3'd4
    } xu_e;

    // Full operation code, {xu, sub}
    typedef enum logic [5:0] {
        ADD   = {3'd0, 3'd0},
        SUB   = {3'd0, 3'd1},
        AND   = {3'd0, 3'd2},
        OR    = {3'd0, 3'd3},
        XOR   = {3'd0, 3'd4},
        SLT   = {3'd0, 3'd5},
        SLL   = {3'd0, 3'd6},
        SRL   = {3'd0, 3'd7},
        JAL   = {3'd1, 3'd0},
        JALR  = {3'd1, 3'd1},
        BR    = {3'd1, 3'd2},
        LB    = {3'd2, 3'd0},
        LBU   = {3'd2, 3'd1},
        LH    = {3'd2, 3'd2},
        LHU   = {3'd2, 3'd3},
        LW    = {3'd2, 3'd4},
        SB    = {3'd2, 3'd5},
        SH    = {3'd2, 3'd6},
        SW    = {3'd2, 3'd7},
        CSRRW = {3'd3, 3'd0},
        CSRRS = {3'd3, 3'd1},
        NOP   = {3'd4, 3'd0},
        ECALL = {3'd4, 3'd1}
    } op_e;

    // Same 6 bits seen as a whole op or as {xu, sub} fields
    // part[1] holds the xu_e code, part[0] the sub code
    typedef union packed {
        op_e              op;
        logic [1:0][2:0]  part;
    } op_u;

endpackage

// ==== rtl/retire_evt_if.sv ====
`timescale 1ns/1ps
// One commit event per accepted result, retire unit to status block
// valid is a single-cycle pulse; the other fields qualify it
interface retire_evt_if import retire_pkg::*; ();

    logic            valid;         // One pulse per accepted result
    logic            killed;        // Result was stale
    logic            exception;     // Live result raised an exception
    logic [XLEN-1:0] pc;            // pc of the committed instruction
    logic [XLEN-1:0] instr;         // Instruction word

    modport source (
        output valid, killed, exception, pc, instr
    );

    modport sink (
        input valid, killed, exception, pc, instr
    );

endinterface

// ==== rtl/load_extend.sv ====
`timescale 1ns/1ps
// Load data alignment for the writeback path
// Picks byte, halfword or word from the loaded data and extends it per the load op;
// any non-load op yields zero
module load_extend import retire_pkg::*; (
    input  op_u             op,             // Full op view used here
    input  logic [XLEN-1:0] load_data,      // Raw word from memory
    output logic [XLEN-1:0] ext_data        // Extended value for writeback
);

    always_comb begin
        case (op.op)
            LB: begin
                ext_data = {{(XLEN-8){load_data[7]}}, load_data[7:0]};      // Sign extend byte
            end
            LBU: begin
                ext_data = {{(XLEN-8){1'b0}}, load_data[7:0]};              // Zero extend byte
            end
            LH: begin
                ext_data = {{(XLEN-16){load_data[15]}}, load_data[15:0]};   // Sign extend half
            end
            LHU: begin
                ext_data = {{(XLEN-16){1'b0}}, load_data[15:0]};            // Zero extend half
            end
            LW: begin
                ext_data = load_data;                                       // Full word
            end
            default: begin
                ext_data = '0;                                              // Stores and others
            end
        endcase
    end

endmodule

// ==== rtl/reg_bank.sv ====
`timescale 1ns/1ps
// Integer register file, 32 x XLEN
// One synchronous write port from retire, one combinational read port;
// x0 ignores writes and always reads zero
module reg_bank import retire_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic [REG_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    input  logic [REG_AW-1:0] rd_addr,
    output logic [XLEN-1:0]   rd_data
);

    localparam int NREG = 1 << REG_AW;

    logic [XLEN-1:0] regs [NREG];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < NREG; i++)
                regs[i] <= '0;                      // Whole bank cleared
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;               // x0 writes dropped
        end
    end

    // Read is combinational
    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

// ==== rtl/retire_unit.sv ====
`timescale 1ns/1ps
// Retire stage of the in-order RV32 pipeline
// Compares each result's tag with the local epoch; stale results are killed,
// live ones write the register bank, redirect fetch, issue stores or raise exceptions.
// Effects appear one cycle after the accept edge
module retire_unit import retire_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic              clk,
    input  logic              reset,
    // Result input, valid/ready
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [TAG_W-1:0]  in_tag,         // Epoch tag from execute
    input  op_u               in_op,
    input  logic              in_we,          // Result has a destination
    input  logic [REG_AW-1:0] in_rd,
    input  logic [XLEN-1:0]   in_result0,     // Write or store value
    input  logic [XLEN-1:0]   in_result1,     // Jump target or store address
    input  logic              in_jump,        // Taken jump
    input  logic [STRB_W-1:0] in_store_mask,  // Nonzero means store
    input  logic [XLEN-1:0]   in_load_data,
    input  logic              in_exception,
    input  logic [XLEN-1:0]   in_pc,
    input  logic [XLEN-1:0]   in_instr,
    // Store output, valid/ready
    output logic              store_valid,
    input  logic              store_ready,
    output logic [XLEN-1:0]   store_addr,
    output logic [XLEN-1:0]   store_data,
    output logic [STRB_W-1:0] store_mask,
    // Fetch redirect
    output logic              redirect_valid,  // One-cycle pulse
    output logic [XLEN-1:0]   redirect_pc,
    // Register bank write
    output logic              wr_en,
    output logic [REG_AW-1:0] wr_addr,
    output logic [XLEN-1:0]   wr_data,
    retire_evt_if.source      evt
);

    logic [TAG_W-1:0] epoch;        // Current epoch
    logic             run_q;        // Low only during the reset cycle
    logic             stall;        // Store held by the consumer
    logic             accept;       // Handshake on this edge
    logic             killed;       // Stale tag
    logic             live;         // Accepted and not killed
    logic             commit;       // Live and no exception
    logic             store_go;     // Live store to issue
    logic [XLEN-1:0]  ld_ext;
    xu_e              xu;

    assign xu       = xu_e'(in_op.part[1]);           // Execution unit field
    assign stall    = store_valid & ~store_ready;
    assign in_ready = run_q & ~stall;
    assign accept   = in_valid & in_ready;
    assign killed   = (in_tag != epoch);              // Stale result
    assign live     = accept & ~killed;
    assign commit   = live & ~in_exception;           // Exceptions suppress side effects
    assign store_go = commit & (in_store_mask != '0);

    load_extend u_load_extend (
        .op        (in_op),
        .load_data (in_load_data),
        .ext_data  (ld_ext)
    );

    // Writeback lands on the accept edge
    assign wr_en   = commit & in_we;
    assign wr_addr = in_rd;
    assign wr_data = (xu == memory) ? ld_ext : in_result0;   // Loads take extended data

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            run_q <= 1'b0;
            epoch <= '0;
        end else begin
            run_q <= 1'b1;
            if (live && in_jump)
                epoch <= epoch + 1'b1;                // New epoch after a taken jump
        end
    end

    // Store valid, held until the consumer takes it
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            store_valid <= 1'b0;
        else if (store_go)
            store_valid <= 1'b1;
        else if (store_ready)
            store_valid <= 1'b0;                      // Transfer done
    end

    always_ff @(posedge clk) begin
        if (store_go) begin
            store_addr <= in_result1;
            store_data <= in_result0;
            store_mask <= in_store_mask;
        end
    end

    // Redirect and commit event pulses
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            redirect_valid <= 1'b0;
            evt.valid      <= 1'b0;
            evt.killed     <= 1'b0;
            evt.exception  <= 1'b0;
        end else begin
            redirect_valid <= live & in_jump;         // Also for excepting jumps
            evt.valid      <= accept;
            evt.killed     <= accept & killed;
            evt.exception  <= live & in_exception;
        end
    end

    always_ff @(posedge clk) begin
        if (live && in_jump)
            redirect_pc <= in_result1;
        if (accept) begin
            evt.pc    <= in_pc;
            evt.instr <= in_instr;
        end
    end

    // Stalled store keeps its fields until taken
    a_store_stable: assert property (@(posedge clk) disable iff (!reset)
        stall |=> store_valid && $stable(store_addr) && $stable(store_data)
                  && $stable(store_mask));

    // Killed result leaves no redirect behind
    a_no_redirect_killed: assert property (@(posedge clk) disable iff (!reset)
        (accept && killed) |=> !redirect_valid);

    a_no_write_killed: assert property (@(posedge clk) disable iff (!reset)
        (accept && killed) |-> !wr_en);

endmodule

// ==== rtl/retire_status.sv ====
`timescale 1ns/1ps
// Commit status beside the retire unit
// Counts retired and killed results and keeps a sticky exception flag with the
// pc and instruction of the first live exception; software clears the flag
module retire_status import retire_pkg::*; #(
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             reset,
    retire_evt_if.sink       evt,
    input  logic             exception_clear,   // Lowers the flag next edge
    output logic             exception_flag,
    output logic [XLEN-1:0]  exception_pc,
    output logic [XLEN-1:0]  exception_instr,
    output logic [CNT_W-1:0] retired_count,
    output logic [CNT_W-1:0] killed_count
);

    logic capture;          // First live exception while flag low

    assign capture = evt.valid & evt.exception & ~exception_flag;

    // Wrapping event counters
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            retired_count <= '0;
            killed_count  <= '0;
        end else if (evt.valid) begin
            if (evt.killed)
                killed_count <= killed_count + 1'b1;
            else
                retired_count <= retired_count + 1'b1;   // Live, with or without exception
        end
    end

    // Sticky flag; a capture can only happen while it is low
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            exception_flag <= 1'b0;
        else if (capture)
            exception_flag <= 1'b1;
        else if (exception_clear)
            exception_flag <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            exception_pc    <= evt.pc;      // Later exceptions do not overwrite
            exception_instr <= evt.instr;
        end
    end

    // Killed results never carry an exception
    a_evt_kill_exc: assert property (@(posedge clk) disable iff (!reset)
        evt.valid |-> !(evt.killed && evt.exception));

endmodule

// ==== rtl/retire_top.sv ====
`timescale 1ns/1ps
// Top level of the commit back end
// Ties the retire unit, status block and register bank together and exposes
// the result input, store port, redirect, debug read and status as plain ports
module retire_top import retire_pkg::*; #(
    parameter int TAG_W = 4,    // Epoch tag width
    parameter int CNT_W = 16    // Status counter width
) (
    input  logic              clk,
    input  logic              reset,
    // Result input
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [TAG_W-1:0]  in_tag,
    input  op_u               in_op,
    input  logic              in_we,
    input  logic [REG_AW-1:0] in_rd,
    input  logic [XLEN-1:0]   in_result0,
    input  logic [XLEN-1:0]   in_result1,
    input  logic              in_jump,
    input  logic [STRB_W-1:0] in_store_mask,
    input  logic [XLEN-1:0]   in_load_data,
    input  logic              in_exception,
    input  logic [XLEN-1:0]   in_pc,
    input  logic [XLEN-1:0]   in_instr,
    // Store output
    output logic              store_valid,
    input  logic              store_ready,
    output logic [XLEN-1:0]   store_addr,
    output logic [XLEN-1:0]   store_data,
    output logic [STRB_W-1:0] store_mask,
    // Redirect
    output logic              redirect_valid,
    output logic [XLEN-1:0]   redirect_pc,
    // Debug read
    input  logic [REG_AW-1:0] rd_addr,
    output logic [XLEN-1:0]   rd_data,
    // Exception status
    input  logic              exception_clear,
    output logic              exception_flag,
    output logic [XLEN-1:0]   exception_pc,
    output logic [XLEN-1:0]   exception_instr,
    output logic [CNT_W-1:0]  retired_count,
    output logic [CNT_W-1:0]  killed_count
);

    logic              wr_en;
    logic [REG_AW-1:0] wr_addr;
    logic [XLEN-1:0]   wr_data;

    retire_evt_if evt_bus ();       // Commit events to status

    retire_unit #(
        .TAG_W (TAG_W)
    ) u_retire_unit (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_tag         (in_tag),
        .in_op          (in_op),
        .in_we          (in_we),
        .in_rd          (in_rd),
        .in_result0     (in_result0),
        .in_result1     (in_result1),
        .in_jump        (in_jump),
        .in_store_mask  (in_store_mask),
        .in_load_data   (in_load_data),
        .in_exception   (in_exception),
        .in_pc          (in_pc),
        .in_instr       (in_instr),
        .store_valid    (store_valid),
        .store_ready    (store_ready),
        .store_addr     (store_addr),
        .store_data     (store_data),
        .store_mask     (store_mask),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .evt            (evt_bus.source)
    );

    retire_status #(
        .CNT_W (CNT_W)
    ) u_retire_status (
        .clk             (clk),
        .reset           (reset),
        .evt             (evt_bus.sink),
        .exception_clear (exception_clear),
        .exception_flag  (exception_flag),
        .exception_pc    (exception_pc),
        .exception_instr (exception_instr),
        .retired_count   (retired_count),
        .killed_count    (killed_count)
    );

    reg_bank u_reg_bank (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// ==== sim/tb_retire_top.sv ====
`timescale 1ns/1ps
// Self-checking testbench for the commit back end
// Drives random results on the falling edge, runs a reference model of the commit
// rules beside the DUT and compares the visible outputs every cycle
module tb_retire_top import retire_pkg::*; ();

    localparam int TAG_W    = 4;
    localparam int CNT_W    = 16;
    localparam int NCYCLES  = 1500;             // Random result cycles
    localparam int WAIT_MAX = 64;               // Cycle limit for every wait

    logic clk, reset, in_valid, in_ready, in_we, in_jump, in_exception;
    logic [TAG_W-1:0] in_tag;
    op_u in_op;
    logic [REG_AW-1:0] in_rd, rd_addr;
    logic [XLEN-1:0] in_result0, in_result1, in_load_data, in_pc, in_instr, rd_data;
    logic [STRB_W-1:0] in_store_mask, store_mask;
    logic store_valid, store_ready, redirect_valid, exception_clear, exception_flag;
    logic [XLEN-1:0] store_addr, store_data, redirect_pc, exception_pc, exception_instr;
    logic [CNT_W-1:0] retired_count, killed_count;

    integer seed;
    int data_errors;
    int timeout_errors;

    logic [TAG_W-1:0] m_epoch;                  // Model state follows
    logic [XLEN-1:0] m_regs [32];
    logic [CNT_W-1:0] m_retired, m_killed;
    logic m_flag, m_store_valid, m_redirect_v, m_evt_v, m_evt_killed, m_evt_exc;
    logic [XLEN-1:0] m_exc_pc, m_exc_instr, m_redirect_pc, m_evt_pc, m_evt_instr;
    logic [XLEN-1:0] q_addr [$];                // Stores in issue order
    logic [XLEN-1:0] q_data [$];
    logic [STRB_W-1:0] q_mask [$];
    logic was_stalled;                          // Store held last cycle
    logic [XLEN-1:0] held_addr, held_data;
    logic [STRB_W-1:0] held_mask;
    op_e op_pool [16] = '{ADD, XOR, SLL, CSRRW, NOP, JAL, JALR, BR,
                          LB, LBU, LH, LHU, LW, SB, SH, SW};

    retire_top #(.TAG_W(TAG_W), .CNT_W(CNT_W)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
                             input logic [TAG_W-1:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            data_errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_store(input logic [XLEN-1:0] exp_addr, input logic [XLEN-1:0] exp_data,
                               input logic [STRB_W-1:0] exp_mask);
        check_word("store_addr", store_addr, exp_addr);
        check_word("store_data", store_data, exp_data);
        if (store_mask !== exp_mask) begin
            data_errors++;
            $display("error at %0t: store_mask got %h expected %h", $time, store_mask, exp_mask);
        end
    endtask

    task automatic finish_run();
        $display("error counts: %0d data, %0d timeout", data_errors, timeout_errors);
        if (data_errors == 0 && timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // Byte, half or word of the loaded data, zero for anything but a load
    function automatic logic [XLEN-1:0] extend_load(input op_e op, input logic [XLEN-1:0] d);
        case (op)
            LB:      return {{24{d[7]}}, d[7:0]};
            LBU:     return {24'd0, d[7:0]};
            LH:      return {{16{d[15]}}, d[15:0]};
            LHU:     return {16'd0, d[15:0]};
            LW:      return d;
            default: return '0;
        endcase
    endfunction

    task automatic drive_inputs(input bit quiet);
        in_op.op        = op_pool[$random(seed) & 15];
        in_valid        = !quiet && (($random(seed) & 7) != 0);
        in_tag          = m_epoch;
        if (($random(seed) & 3) == 0)
            in_tag = m_epoch - TAG_W'(1 + ($random(seed) & 3));    // Tag of an older epoch
        in_we           = ($random(seed) & 3) != 0;
        in_rd           = REG_AW'($random(seed));
        in_result0      = $random(seed);
        in_result1      = $random(seed);
        in_load_data    = $random(seed);
        in_pc           = $random(seed) & 32'hffff_fffc;
        in_instr        = $random(seed);
        in_jump         = (in_op.part[1] == branch) && (($random(seed) & 3) != 0);
        in_store_mask   = (in_op.op inside {SB, SH, SW}) ? STRB_W'($random(seed) | 1) : '0;
        in_exception    = ($random(seed) & 15) == 0;
        store_ready     = quiet || (($random(seed) & 3) != 0);   // Stall about a quarter
        exception_clear = !quiet && (($random(seed) & 15) == 0);
        rd_addr         = REG_AW'($random(seed));
    endtask

    task automatic check_state();
        check_flag("redirect_valid", redirect_valid, m_redirect_v);
        if (m_redirect_v)
            check_word("redirect_pc", redirect_pc, m_redirect_pc);
        check_flag("store_valid", store_valid, m_store_valid);
        check_flag("exception_flag", exception_flag, m_flag);
        if (m_flag) begin
            check_word("exception_pc", exception_pc, m_exc_pc);
            check_word("exception_instr", exception_instr, m_exc_instr);
        end
        check_count("retired_count", retired_count, m_retired);
        check_count("killed_count", killed_count, m_killed);
        check_tag("epoch", u_dut.u_retire_unit.epoch, m_epoch);
        if (was_stalled)                                        // Held store unchanged
            check_store(held_addr, held_data, held_mask);
    endtask

    // One clock of stimulus, checks and model update
    task automatic step(input bit quiet);
        logic ready, acc, kill, live, commit;
        @(negedge clk);
        check_state();
        drive_inputs(quiet);
        #1;
        ready = !(m_store_valid && !store_ready);
        check_flag("in_ready", in_ready, ready);
        check_word("rd_data", rd_data, m_regs[rd_addr]);
        if (store_valid && store_ready) begin                   // Transfer on next edge
            if (q_addr.size() == 0) begin
                data_errors++;
                $display("store transfer at %0t when no store was expected", $time);
            end else begin
                check_store(q_addr.pop_front(), q_data.pop_front(), q_mask.pop_front());
            end
        end
        was_stalled = store_valid && !store_ready;
        held_addr   = store_addr;
        held_data   = store_data;
        held_mask   = store_mask;
        acc    = in_valid && ready;
        kill   = acc && (in_tag != m_epoch);
        live   = acc && !kill;
        commit = live && !in_exception;
        if (m_evt_v && m_evt_killed)
            m_killed++;
        else if (m_evt_v)
            m_retired++;
        if (m_evt_v && m_evt_exc && !m_flag) begin              // First exception only
            m_flag      = 1'b1;
            m_exc_pc    = m_evt_pc;
            m_exc_instr = m_evt_instr;
        end else if (exception_clear) begin
            m_flag = 1'b0;
        end
        if (commit && in_store_mask != '0) begin
            q_addr.push_back(in_result1);
            q_data.push_back(in_result0);
            q_mask.push_back(in_store_mask);
            m_store_valid = 1'b1;
        end else if (store_ready) begin
            m_store_valid = 1'b0;
        end
        if (commit && in_we && in_rd != '0)
            m_regs[in_rd] = (in_op.part[1] == memory) ? extend_load(in_op.op, in_load_data)
                                                      : in_result0;
        m_redirect_v  = live && in_jump;
        m_redirect_pc = in_result1;
        if (live && in_jump)
            m_epoch++;                                          // New epoch
        m_evt_v      = acc;
        m_evt_killed = kill;
        m_evt_exc    = live && in_exception;
        m_evt_pc     = in_pc;
        m_evt_instr  = in_instr;
    endtask

    initial begin
        int i;
        int n;
        seed = 38420;
        data_errors = 0;
        timeout_errors = 0;
        {reset, in_valid, in_we, in_jump, in_exception, store_ready, exception_clear} = '0;
        {in_tag, in_rd, rd_addr, in_store_mask} = '0;
        {in_result0, in_result1, in_load_data, in_pc, in_instr} = '0;
        in_op.op = NOP;
        {m_epoch, m_retired, m_killed, m_flag, m_store_valid, m_redirect_v} = '0;
        {m_evt_v, m_evt_killed, m_evt_exc, was_stalled} = '0;
        for (i = 0; i < 32; i++)
            m_regs[i] = '0;
        @(negedge clk);
        check_flag("in_ready", in_ready, 1'b0);                 // Low while in reset
        @(negedge clk);
        reset = 1'b1;
        n = 0;
        while (in_ready !== 1'b1 && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (in_ready !== 1'b1) begin
            timeout_errors++;
            $display("timeout: in_ready never rose after reset was released");
        end else begin
            check_state();
            for (i = 0; i < 32; i++) begin                      // Whole bank reads zero
                rd_addr = REG_AW'(i);
                #0.5;
                check_word("rd_data", rd_data, '0);
            end
            for (i = 0; i < NCYCLES; i++)
                step(1'b0);
            n = 0;
            while ((m_store_valid || m_evt_v || store_valid) && n < WAIT_MAX) begin
                step(1'b1);                                     // Drain stores and events
                n++;
            end
            if (m_store_valid || store_valid) begin
                timeout_errors++;
                $display("timeout: pending store never drained at the end of the run");
            end
            step(1'b1);
            step(1'b1);
            if (q_addr.size() != 0) begin
                data_errors++;
                $display("%0d expected stores were never transferred", q_addr.size());
            end
        end
        finish_run();
    end

endmodule

// ==== retire.f ====
rtl/retire_pkg.sv
rtl/retire_evt_if.sv
rtl/load_extend.sv
rtl/reg_bank.sv
rtl/retire_unit.sv
rtl/retire_status.sv
rtl/retire_top.sv
sim/tb_retire_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the retire back end testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f retire.f \
    --top-module tb_retire_top -o sim_retire
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_retire)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
